/* Bender.yml */
package:
  name: fetch_stage

sources:
  - fetch_pkg.sv
  - branch_target.sv
  - fetch_bus_master.sv
  - pc_sequencer.sv
  - fetch_top.sv
  - target: simulation
    files:
      - tb_imem.sv
      - fetch_asserts.sv
      - fetch_tb.sv

/* branch_target.sv */
`timescale 1ns/100ps

module branch_target import fetch_pkg::*; (
    input  logic                 me_jal_i,
    input  logic                 me_jalr_i,
    input  logic                 me_branch_i,
    input  logic                 trap_i,
    input  logic [XLEN-1:0]      me_alu_res_i,
    input  logic [XLEN-1:0]      me_pc_i,
    input  logic [XLEN-1:0]      me_imm_i,
    input  logic [XLEN-1:0]      me_rs1_i,
    input  logic [XLEN-1:0]      mtvec_i,
    output redirect_kind_e       redirect_kind_o,
    output logic [XLEN-1:0]      redirect_target_o
);

    logic            branch_taken;
    logic [XLEN-1:0] pc_rel_target;
    logic [XLEN-1:0] jalr_sum;

    // branch compare result comes from the alu, zero means taken
    assign branch_taken = me_branch_i && (me_alu_res_i == '0);

    // jal and branch share the pc relative adder
    assign pc_rel_target = me_pc_i + me_imm_i;
    assign jalr_sum      = me_rs1_i + me_imm_i;

    always_comb begin
        redirect_kind_o   = REDIR_NONE;
        redirect_target_o = pc_rel_target;
        if (me_jal_i) begin
            redirect_kind_o   = REDIR_JAL;
            redirect_target_o = pc_rel_target;
        end else if (branch_taken) begin
            redirect_kind_o   = REDIR_BRANCH;
            redirect_target_o = pc_rel_target;
        end else if (me_jalr_i) begin
            // jalr clears the lsb of the sum
            redirect_kind_o   = REDIR_JALR;
            redirect_target_o = {jalr_sum[XLEN-1:1], 1'b0};
        end else if (trap_i) begin
            redirect_kind_o   = REDIR_TRAP;
            redirect_target_o = mtvec_i;
        end
    end

endmodule

/* fetch_asserts.sv */
`timescale 1ns/100ps

module fetch_asserts import fetch_pkg::*; (
    input logic            clk,
    input logic            rst_n_i,
    input logic            addr_valid_i,
    input logic [XLEN-1:0] addr_i,
    input logic            addr_ready_i,
    input logic            data_ready_i,
    input logic            rsp_valid_i
);

    int assert_errors = 0;

    // address and valid held until the memory takes them
    addr_stable_a: assert property (@(posedge clk) disable iff (!rst_n_i)
        addr_valid_i && !addr_ready_i |=> addr_valid_i && $stable(addr_i))
        else begin
            assert_errors++;
            $error("address phase changed before it was accepted");
        end

    // data phase opens right after the accepted address, with valid already dropped
    data_after_addr_a: assert property (@(posedge clk) disable iff (!rst_n_i)
        addr_valid_i && addr_ready_i |=> data_ready_i && !addr_valid_i)
        else begin
            assert_errors++;
            $error("data ready did not follow the accepted address on its own");
        end

    rsp_pulse_a: assert property (@(posedge clk) disable iff (!rst_n_i)
        rsp_valid_i |=> !rsp_valid_i)
        else begin
            assert_errors++;
            $error("response valid held longer than one cycle");
        end

endmodule

bind fetch_bus_master fetch_asserts u_fetch_asserts (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .addr_valid_i (mem_addr_valid_o),
    .addr_i       (mem_addr_o),
    .addr_ready_i (mem_addr_ready_i),
    .data_ready_i (mem_data_ready_o),
    .rsp_valid_i  (rsp_valid_o)
);

/* fetch_bus_master.sv */
`timescale 1ns/100ps

module fetch_bus_master import fetch_pkg::*; (
    input  logic             clk,
    input  logic             rst_n_i,
    // next address to fetch, the current pc
    input  logic [XLEN-1:0]  req_addr_i,
    // address phase
    output logic             mem_addr_valid_o,
    output logic [XLEN-1:0]  mem_addr_o,
    input  logic             mem_addr_ready_i,
    // data phase
    input  logic             mem_data_valid_i,
    input  logic [XLEN-1:0]  mem_data_i,
    output logic             mem_data_ready_o,
    // response to the pc sequencer
    output logic             rsp_valid_o,
    output logic [XLEN-1:0]  rsp_addr_o,
    output logic [ILEN-1:0]  rsp_data_o
);

    bus_state_e      state_q;
    bus_state_e      state_d;
    logic [XLEN-1:0] addr_q;
    logic            addr_done;
    logic            data_done;

    assign addr_done = mem_addr_valid_o && mem_addr_ready_i;
    assign data_done = mem_data_valid_i && mem_data_ready_o;

    // handshake outputs follow the state directly
    assign mem_addr_valid_o = (state_q == BUS_ADDR);
    assign mem_data_ready_o = (state_q == BUS_DATA);
    assign mem_addr_o       = addr_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            BUS_IDLE: begin
                state_d = BUS_ADDR;
            end
            BUS_ADDR: begin
                if (addr_done) begin
                    state_d = BUS_DATA;
                end
            end
            BUS_DATA: begin
                // a started read always runs to completion
                if (data_done) begin
                    state_d = BUS_IDLE;
                end
            end
            default: begin
                state_d = BUS_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q <= BUS_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // capture the pc as the request leaves idle
    // it stays put until the data phase ends
    always_ff @(posedge clk) begin
        if (state_q == BUS_IDLE) begin
            addr_q <= req_addr_i;
        end
    end

    // response pulse in the cycle the data phase completes
    assign rsp_valid_o = data_done;
    assign rsp_addr_o  = addr_q;
    // only the low word of the doubleword carries the instruction
    assign rsp_data_o  = mem_data_i[ILEN-1:0];

endmodule

/* fetch_pkg.sv */
package fetch_pkg;

    // datapath and instruction widths
    localparam int XLEN = 64;
    localparam int ILEN = 32;

    // first fetch address after reset
    localparam logic [XLEN-1:0] RESET_PC = 64'h0000_0000_8000_0000;

    // no compressed instructions, so the pc always steps by a full word
    localparam logic [XLEN-1:0] INST_BYTES = 64'd4;

    // redirect kinds reported by the memory stage
    typedef enum logic [2:0] {
        REDIR_NONE   = 3'd0,
        REDIR_BRANCH = 3'd1,
        REDIR_JAL    = 3'd2,
        REDIR_JALR   = 3'd3,
        REDIR_TRAP   = 3'd4
    } redirect_kind_e;

    // read channel states
    // address phase and data phase are separate handshakes
    typedef enum logic [1:0] {
        BUS_IDLE = 2'd0,
        BUS_ADDR = 2'd1,
        BUS_DATA = 2'd2
    } bus_state_e;

endpackage

/* fetch_tb.sv */
`timescale 1ns/100ps

module fetch_tb import fetch_pkg::*; ();

    localparam logic [ILEN-1:0] INST_PATTERN = 32'h5a3c_96e1;

    logic clk = 1'b0;
    logic rst_n, stall, jal, jalr, branch, trap;
    logic [XLEN-1:0] alu_res, me_pc, me_imm, me_rs1, mtvec;
    logic inst_valid, mem_addr_valid, mem_addr_ready, mem_data_valid, mem_data_ready;
    logic [ILEN-1:0] inst;
    logic [XLEN-1:0] inst_pc, mem_addr, mem_data;
    logic [XLEN-1:0] exp_pc;
    logic stall_q = 1'b0;
    string test_name = "reset";
    integer seed = 32'hc99e53ee;
    int checked_cnt = 0;
    int mismatch_errors = 0;
    int stall_errors = 0;
    int timeout_errors = 0;
    int total_errors;

    always #4 clk = ~clk;

    fetch_top DUT (
        .clk(clk), .rst_n_i(rst_n), .me_jal_i(jal), .me_jalr_i(jalr), .me_branch_i(branch),
        .trap_i(trap), .me_alu_res_i(alu_res), .me_pc_i(me_pc), .me_imm_i(me_imm),
        .me_rs1_i(me_rs1), .mtvec_i(mtvec), .stall_i(stall), .inst_valid_o(inst_valid),
        .inst_o(inst), .inst_pc_o(inst_pc), .mem_addr_valid_o(mem_addr_valid),
        .mem_addr_o(mem_addr), .mem_addr_ready_i(mem_addr_ready),
        .mem_data_valid_i(mem_data_valid), .mem_data_i(mem_data),
        .mem_data_ready_o(mem_data_ready)
    );

    tb_imem #(.PATTERN(INST_PATTERN)) u_imem (
        .clk(clk), .rst_n_i(rst_n), .addr_valid_i(mem_addr_valid), .addr_i(mem_addr),
        .addr_ready_o(mem_addr_ready), .data_valid_o(mem_data_valid), .data_o(mem_data),
        .data_ready_i(mem_data_ready)
    );

    function automatic logic [ILEN-1:0] exp_inst(input logic [XLEN-1:0] pc);
        return pc[ILEN-1:0] ^ INST_PATTERN;
    endfunction

    // jal or taken branch, then jalr, then trap
    function automatic logic ref_redirect(output logic [XLEN-1:0] target);
        logic [XLEN-1:0] sum;
        sum = me_rs1 + me_imm;
        target = '0;
        ref_redirect = 1'b1;
        if (jal || (branch && alu_res == '0)) begin
            target = me_pc + me_imm;
        end else if (jalr) begin
            target = sum & ~64'd1;
        end else if (trap) begin
            target = mtvec;
        end else begin
            ref_redirect = 1'b0;
        end
    endfunction

    task automatic check_pc(input string name, input logic [XLEN-1:0] exp,
                            input logic [XLEN-1:0] act);
        if (act !== exp) begin
            mismatch_errors++;
            $display("mismatch in %s: pc expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_inst(input string name, input logic [ILEN-1:0] exp,
                              input logic [ILEN-1:0] act);
        if (act !== exp) begin
            mismatch_errors++;
            $display("mismatch in %s: inst expected %h, actual %h", name, exp, act);
        end
    endtask

    // scoreboard, old path outputs are checked before the redirect applies
    always @(posedge clk) begin
        logic [XLEN-1:0] target;
        logic            redir;
        if (!rst_n) begin
            exp_pc = RESET_PC;
        end else begin
            if (inst_valid) begin
                if (stall_q) begin
                    stall_errors++;
                    $display("instruction delivered while stalled in %s", test_name);
                end
                check_pc(test_name, exp_pc, inst_pc);
                check_inst(test_name, exp_inst(exp_pc), inst);
                exp_pc = exp_pc + INST_BYTES;
                checked_cnt++;
            end
            redir = ref_redirect(target);
            if (redir) begin
                exp_pc = target;
            end
        end
        stall_q = stall;
    end

    task automatic wait_outputs(input int n);
        int target;
        int cycles;
        target = checked_cnt + n;
        cycles = 0;
        while (checked_cnt < target && cycles < 50 * n) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (checked_cnt < target) begin
            timeout_errors++;
            $display("timeout in %s: no instruction after %0d cycles", test_name, cycles);
        end
    endtask

    task automatic fire_redirect(input logic j, jr, br, tr,
                                 input logic [XLEN-1:0] alu, pc, imm, rs1, tvec);
        jal = j;
        jalr = jr;
        branch = br;
        trap = tr;
        alu_res = alu;
        me_pc = pc;
        me_imm = imm;
        me_rs1 = rs1;
        mtvec = tvec;
        @(posedge clk);
        #1;
        {jal, jalr, branch, trap} = 4'b0000;
    endtask

    task automatic random_redirect();
        logic [31:0]     r;
        logic [XLEN-1:0] base;
        r = $random(seed);
        base = RESET_PC + (r & 32'h0000_fffc);
        case ($unsigned($random(seed)) % 4)
            0: fire_redirect(1, 0, 0, 0, '0, base, 64'h40, '0, '0);
            1: fire_redirect(0, 0, 1, 0, {63'd0, r[16]}, base, 64'h80, '0, '0);
            2: fire_redirect(0, 1, 0, 0, '0, '0, {52'd0, r[27:16]}, base + 1, '0);
            default: fire_redirect(0, 0, 0, 1, '0, '0, '0, '0, base + 64'h2000);
        endcase
    endtask

    initial begin
        rst_n = 1'b0;
        stall = 1'b0;
        {jal, jalr, branch, trap} = 4'b0000;
        {alu_res, me_pc, me_imm, me_rs1, mtvec} = '0;
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        test_name = "sequential";
        wait_outputs(8);
        test_name = "jal";
        fire_redirect(1, 0, 0, 0, '0, RESET_PC + 64'h100, 64'h40, '0, '0);
        wait_outputs(3);
        test_name = "branch_taken";
        fire_redirect(0, 0, 1, 0, '0, RESET_PC + 64'h200, 64'h80, '0, '0);
        wait_outputs(3);
        test_name = "branch_not_taken";
        fire_redirect(0, 0, 1, 0, 64'h1, RESET_PC + 64'h300, 64'h80, '0, '0);
        wait_outputs(3);
        test_name = "jalr_odd";
        fire_redirect(0, 1, 0, 0, '0, '0, 64'h20, RESET_PC + 64'h501, '0);
        wait_outputs(3);
        test_name = "trap";
        fire_redirect(0, 0, 0, 1, '0, '0, '0, '0, RESET_PC + 64'h1000);
        wait_outputs(3);
        test_name = "priority";
        fire_redirect(1, 1, 0, 1, '0, RESET_PC + 64'h600, 64'h10, RESET_PC, RESET_PC + 64'h1000);
        wait_outputs(3);
        test_name = "stall";
        stall = 1'b1;
        repeat (20) @(posedge clk);
        #1;
        stall = 1'b0;
        wait_outputs(4);
        test_name = "random";
        repeat (200) begin
            wait_outputs(1);
            if (($random(seed) & 7) == 0) begin
                random_redirect();
            end
        end
        total_errors = mismatch_errors + stall_errors + timeout_errors
                     + DUT.u_fetch_bus_master.u_fetch_asserts.assert_errors;
        $display("error counts: value %0d, stall %0d, timeout %0d, assertion %0d",
                 mismatch_errors, stall_errors, timeout_errors,
                 DUT.u_fetch_bus_master.u_fetch_asserts.assert_errors);
        if (total_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* fetch_top.sv */
`timescale 1ns/100ps

module fetch_top import fetch_pkg::*; (
    input  logic             clk,
    input  logic             rst_n_i,
    // memory stage redirect sources
    input  logic             me_jal_i,
    input  logic             me_jalr_i,
    input  logic             me_branch_i,
    input  logic             trap_i,
    input  logic [XLEN-1:0]  me_alu_res_i,
    input  logic [XLEN-1:0]  me_pc_i,
    input  logic [XLEN-1:0]  me_imm_i,
    input  logic [XLEN-1:0]  me_rs1_i,
    input  logic [XLEN-1:0]  mtvec_i,
    input  logic             stall_i,
    // to decode
    output logic             inst_valid_o,
    output logic [ILEN-1:0]  inst_o,
    output logic [XLEN-1:0]  inst_pc_o,
    // instruction memory read channel
    output logic             mem_addr_valid_o,
    output logic [XLEN-1:0]  mem_addr_o,
    input  logic             mem_addr_ready_i,
    input  logic             mem_data_valid_i,
    input  logic [XLEN-1:0]  mem_data_i,
    output logic             mem_data_ready_o
);

    redirect_kind_e  redirect_kind;
    logic [XLEN-1:0] redirect_target;
    logic [XLEN-1:0] pc;
    logic            rsp_valid;
    logic [XLEN-1:0] rsp_addr;
    logic [ILEN-1:0] rsp_data;

    branch_target u_branch_target (
        .me_jal_i          (me_jal_i),
        .me_jalr_i         (me_jalr_i),
        .me_branch_i       (me_branch_i),
        .trap_i            (trap_i),
        .me_alu_res_i      (me_alu_res_i),
        .me_pc_i           (me_pc_i),
        .me_imm_i          (me_imm_i),
        .me_rs1_i          (me_rs1_i),
        .mtvec_i           (mtvec_i),
        .redirect_kind_o   (redirect_kind),
        .redirect_target_o (redirect_target)
    );

    fetch_bus_master u_fetch_bus_master (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .req_addr_i       (pc),
        .mem_addr_valid_o (mem_addr_valid_o),
        .mem_addr_o       (mem_addr_o),
        .mem_addr_ready_i (mem_addr_ready_i),
        .mem_data_valid_i (mem_data_valid_i),
        .mem_data_i       (mem_data_i),
        .mem_data_ready_o (mem_data_ready_o),
        .rsp_valid_o      (rsp_valid),
        .rsp_addr_o       (rsp_addr),
        .rsp_data_o       (rsp_data)
    );

    pc_sequencer u_pc_sequencer (
        .clk               (clk),
        .rst_n_i           (rst_n_i),
        .redirect_kind_i   (redirect_kind),
        .redirect_target_i (redirect_target),
        .rsp_valid_i       (rsp_valid),
        .rsp_addr_i        (rsp_addr),
        .rsp_data_i        (rsp_data),
        .stall_i           (stall_i),
        .pc_o              (pc),
        .inst_valid_o      (inst_valid_o),
        .inst_o            (inst_o),
        .inst_pc_o         (inst_pc_o)
    );

endmodule

/* filelist.f */
fetch_pkg.sv
branch_target.sv
fetch_bus_master.sv
pc_sequencer.sv
fetch_top.sv
tb_imem.sv
fetch_asserts.sv
fetch_tb.sv

/* pc_sequencer.sv */
`timescale 1ns/100ps

module pc_sequencer import fetch_pkg::*; (
    input  logic             clk,
    input  logic             rst_n_i,
    // redirect from the target logic
    input  redirect_kind_e   redirect_kind_i,
    input  logic [XLEN-1:0]  redirect_target_i,
    // response from the bus master
    input  logic             rsp_valid_i,
    input  logic [XLEN-1:0]  rsp_addr_i,
    input  logic [ILEN-1:0]  rsp_data_i,
    input  logic             stall_i,
    // pc for the next request
    output logic [XLEN-1:0]  pc_o,
    // fetched instruction to decode
    output logic             inst_valid_o,
    output logic [ILEN-1:0]  inst_o,
    output logic [XLEN-1:0]  inst_pc_o
);

    logic [XLEN-1:0] pc_q;
    logic            redirect;
    logic            rsp_match;
    logic            accept;

    assign redirect  = (redirect_kind_i != REDIR_NONE);

    // responses for an old pc are stale and get dropped
    assign rsp_match = rsp_valid_i && (rsp_addr_i == pc_q);

    // a redirect in the same cycle wins over the response
    // under stall the word is thrown away and refetched later
    assign accept    = rsp_match && !redirect && !stall_i;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            pc_q <= RESET_PC;
        end else if (redirect) begin
            pc_q <= redirect_target_i;
        end else if (accept) begin
            pc_q <= pc_q + INST_BYTES;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            inst_valid_o <= 1'b0;
        end else begin
            inst_valid_o <= accept;
        end
    end

    // payload only, qualified by inst_valid_o
    always_ff @(posedge clk) begin
        if (accept) begin
            inst_o    <= rsp_data_i;
            inst_pc_o <= pc_q;
        end
    end

    assign pc_o = pc_q;

endmodule

/* tb_imem.sv */
`timescale 1ns/100ps

module tb_imem import fetch_pkg::*; #(
    parameter logic [ILEN-1:0] PATTERN = 32'h0
) (
    input  logic             clk,
    input  logic             rst_n_i,
    input  logic             addr_valid_i,
    input  logic [XLEN-1:0]  addr_i,
    output logic             addr_ready_o,
    output logic             data_valid_o,
    output logic [XLEN-1:0]  data_o,
    input  logic             data_ready_i
);

    integer          seed = 32'hc99e53ee;
    logic            in_data = 1'b0;
    logic [XLEN-1:0] addr_q = '0;
    int unsigned     addr_wait = 0;
    int unsigned     data_wait = 0;
    logic            ready_d;
    logic            valid_d;

    initial begin
        addr_ready_o = 1'b0;
        data_valid_o = 1'b0;
        data_o       = '0;
    end

    // handshakes sampled at the edge, outputs move 1 ns later
    always @(posedge clk) begin
        ready_d = 1'b0;
        valid_d = data_valid_o;
        if (!rst_n_i) begin
            in_data   = 1'b0;
            valid_d   = 1'b0;
            addr_wait = 0;
        end else begin
            if (addr_valid_i && addr_ready_o) begin
                in_data   = 1'b1;
                addr_q    = addr_i;
                data_wait = $unsigned($random(seed)) % 4;
            end else if (!in_data && addr_valid_i) begin
                if (addr_wait == 0) begin
                    ready_d = 1'b1;
                end else begin
                    addr_wait = addr_wait - 1;
                end
            end
            if (data_valid_o && data_ready_i) begin
                in_data   = 1'b0;
                valid_d   = 1'b0;
                addr_wait = $unsigned($random(seed)) % 4;
            end else if (in_data && !data_valid_o) begin
                if (data_wait == 0) begin
                    valid_d = 1'b1;
                end else begin
                    data_wait = data_wait - 1;
                end
            end
        end
        #1;
        addr_ready_o = ready_d;
        // upper word folds in the high address bits
        data_o       = {addr_q[XLEN-1:ILEN] ^ ~addr_q[ILEN-1:0], addr_q[ILEN-1:0] ^ PATTERN};
        data_valid_o = valid_d;
    end

endmodule
